// File: rtl/xaui_code_pkg.sv
package xaui_code_pkg;

  // ##############################
  // Lane geometry
  // ##############################

  localparam int lane_count = 4; // Fixed by XAUI.
  localparam int lane_width = 8; // One decoded byte per lane per clock.
  localparam int bus_width = lane_count * lane_width;

  // ##############################
  // Special code groups
  // ##############################

  localparam logic [7:0] sym_k = 8'hbc; // K28.5 comma.
  localparam logic [7:0] sym_a = 8'h7c; // K28.3, lane alignment.
  localparam logic [7:0] sym_r = 8'h1c; // K28.0, skip.

  // ##############################
  // Synchronization thresholds
  // ##############################

  // Clean commas in a row before a lane is in sync.
  localparam int sync_comma_count = 4;
  // Counted errors that drop sync.
  localparam int sync_error_limit = 4;
  // Good groups in a row that forgive one counted error.
  localparam int sync_good_run = 4;

endpackage

// File: rtl/pcs_state_pkg.sv
package pcs_state_pkg;

  // ##############################
  // Per-lane code-group sync
  // ##############################

  typedef enum logic [1:0] {
    loss_of_sync,
    comma_detect,
    sync_acquired
  } sync_state_t;

  // ##############################
  // Lane alignment
  // ##############################

  // Detect states count /A/ columns up from loss of alignment.
  // Acquired states count errors down toward loss of alignment.
  typedef enum logic [2:0] {
    loss_of_alignment,
    align_detect_1,
    align_detect_2,
    align_detect_3,
    align_acquired_1,
    align_acquired_2,
    align_acquired_3,
    align_acquired_4
  } deskew_state_t;

endpackage

// File: rtl/pcs_sync.sv
`timescale 1ns/1ps

module pcs_sync (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] lane_data,
  input  logic       lane_charisk,
  input  logic       lane_disp_err,
  output logic       lane_sync
);

  localparam int comma_w = $clog2(xaui_code_pkg::sync_comma_count + 1);
  localparam int err_w = $clog2(xaui_code_pkg::sync_error_limit + 1);
  localparam int good_w = $clog2(xaui_code_pkg::sync_good_run + 1);

  pcs_state_pkg::sync_state_t state;

  logic [comma_w-1:0] comma_cnt; // Clean commas seen so far.
  logic [err_w-1:0]   err_cnt;
  logic [good_w-1:0]  good_cnt;  // Good run toward forgiving one error.
  logic               good_comma;

  assign good_comma = lane_charisk && (lane_data == xaui_code_pkg::sym_k) && !lane_disp_err;

  // ##############################
  // Sync state machine
  // ##############################

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= pcs_state_pkg::loss_of_sync;
      comma_cnt <= '0;
      err_cnt <= '0;
      good_cnt <= '0;
    end else begin
      case (state)
        pcs_state_pkg::loss_of_sync: begin
          if (good_comma) begin
            comma_cnt <= comma_w'(1);
            state <= pcs_state_pkg::comma_detect;
          end else begin
            comma_cnt <= '0;
          end
        end

        pcs_state_pkg::comma_detect: begin
          if (!good_comma) begin
            comma_cnt <= '0;
            state <= pcs_state_pkg::loss_of_sync; // Run broken, start over.
          end else if (comma_cnt == comma_w'(xaui_code_pkg::sync_comma_count - 1)) begin
            comma_cnt <= '0;
            err_cnt <= '0;
            good_cnt <= '0;
            state <= pcs_state_pkg::sync_acquired;
          end else begin
            comma_cnt <= comma_cnt + 1'b1;
          end
        end

        pcs_state_pkg::sync_acquired: begin
          if (lane_disp_err) begin
            good_cnt <= '0;
            if (err_cnt == err_w'(xaui_code_pkg::sync_error_limit - 1)) begin
              err_cnt <= '0;
              state <= pcs_state_pkg::loss_of_sync;
            end else begin
              err_cnt <= err_cnt + 1'b1;
            end
          end else if (err_cnt != '0) begin
            // A full good run pays back one error.
            if (good_cnt == good_w'(xaui_code_pkg::sync_good_run - 1)) begin
              good_cnt <= '0;
              err_cnt <= err_cnt - 1'b1;
            end else begin
              good_cnt <= good_cnt + 1'b1;
            end
          end
        end

        default: begin
          state <= pcs_state_pkg::loss_of_sync;
        end
      endcase
    end
  end

  assign lane_sync = (state == pcs_state_pkg::sync_acquired);

endmodule

// File: rtl/lane_aligner.sv
`timescale 1ns/1ps

module lane_aligner #(
  parameter int max_skew = 6
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [xaui_code_pkg::bus_width-1:0]  rx_data,
  input  logic [xaui_code_pkg::lane_count-1:0] rx_charisk,
  input  logic [xaui_code_pkg::lane_count-1:0] rx_disp_err,
  input  logic                               enable_deskew,
  output logic [xaui_code_pkg::bus_width-1:0]  aligned_data,
  output logic [xaui_code_pkg::lane_count-1:0] aligned_charisk,
  output logic [xaui_code_pkg::lane_count-1:0] aligned_disp_err
);

  localparam int lanes = xaui_code_pkg::lane_count;
  localparam int lw = xaui_code_pkg::lane_width;
  localparam int depth = max_skew + 1;
  localparam int ptr_w = $clog2(depth);

  // Entries are {disp_err, charisk, data}.
  logic [lw+1:0]    mem [lanes][depth];
  logic [lw+1:0]    entry_in [lanes];
  logic [lw+1:0]    head [lanes];
  logic [ptr_w-1:0] wr_ptr; // Shared, all lanes write together.
  logic [ptr_w-1:0] rd_ptr [lanes];
  logic [ptr_w-1:0] fill [lanes];
  logic [ptr_w-1:0] hold_cnt [lanes];
  logic [lanes-1:0] head_is_a;
  logic [lanes-1:0] hold;
  logic [lanes-1:0] discard;
  logic [lanes-1:0] not_empty;
  logic             all_a;
  logic             drain;

  function automatic logic [ptr_w-1:0] ptr_next(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // ##############################
  // Head selection and hold rule
  // ##############################

  always_comb begin
    for (int l = 0; l < lanes; l++) begin
      entry_in[l] = {rx_disp_err[l], rx_charisk[l], rx_data[l*lw +: lw]};
      fill[l] = wr_ptr - rd_ptr[l];
      if (wr_ptr < rd_ptr[l]) begin
        fill[l] = fill[l] + ptr_w'(depth); // Wrap for odd depths.
      end
      not_empty[l] = (fill[l] != '0);
      head[l] = not_empty[l] ? mem[l][rd_ptr[l]] : entry_in[l]; // Bypass when empty.
      head_is_a[l] = head[l][lw] && (head[l][lw-1:0] == xaui_code_pkg::sym_a);
    end
    all_a = &head_is_a;
    for (int l = 0; l < lanes; l++) begin
      // A lane waits on its /A/ until the others catch up, within limits.
      hold[l] = enable_deskew && head_is_a[l] && !all_a &&
                (hold_cnt[l] < ptr_w'(max_skew)) && (fill[l] < ptr_w'(max_skew));
      discard[l] = enable_deskew && head_is_a[l] && !all_a && !hold[l];
    end
    // Common excess depth is shed by skipping one write on every lane.
    drain = enable_deskew && (&not_empty) && (hold == '0);
  end

  // ##############################
  // Storage and pointers
  // ##############################

  always_ff @(posedge clk) begin
    if (!drain) begin
      for (int l = 0; l < lanes; l++) begin
        mem[l][wr_ptr] <= entry_in[l];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      for (int l = 0; l < lanes; l++) begin
        rd_ptr[l] <= '0;
        hold_cnt[l] <= '0;
      end
      aligned_data <= '0;
      aligned_charisk <= '0;
      aligned_disp_err <= '0;
    end else begin
      if (!drain) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      for (int l = 0; l < lanes; l++) begin
        if (hold[l]) begin
          hold_cnt[l] <= hold_cnt[l] + 1'b1;
        end else begin
          hold_cnt[l] <= '0;
          rd_ptr[l] <= ptr_next(rd_ptr[l]);
          if (!discard[l]) begin
            aligned_data[l*lw +: lw] <= head[l][lw-1:0];
            aligned_charisk[l] <= head[l][lw];
            aligned_disp_err[l] <= head[l][lw+1];
          end
        end
      end
    end
  end

endmodule

// File: rtl/pcs_deskew.sv
`timescale 1ns/1ps

module pcs_deskew (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [xaui_code_pkg::bus_width-1:0]  aligned_data,
  input  logic [xaui_code_pkg::lane_count-1:0] aligned_charisk,
  input  logic [xaui_code_pkg::lane_count-1:0] aligned_disp_err,
  input  logic [xaui_code_pkg::lane_count-1:0] sync_status,
  output logic                               enable_deskew,
  output logic                               align_status
);

  localparam int lanes = xaui_code_pkg::lane_count;
  localparam int lw = xaui_code_pkg::lane_width;

  pcs_state_pkg::deskew_state_t state;
  pcs_state_pkg::deskew_state_t next_state;

  logic [lanes-1:0] lane_a; // Lanes carrying /A/ this cycle.
  logic             got_align;
  logic             align_error;

  always_comb begin
    for (int l = 0; l < lanes; l++) begin
      lane_a[l] = aligned_charisk[l] && (aligned_data[l*lw +: lw] == xaui_code_pkg::sym_a);
    end
  end

  assign got_align = &lane_a;
  assign align_error = (|aligned_disp_err) || ((|lane_a) && !(&lane_a)); // Partial column.

  // ##############################
  // Alignment state machine
  // ##############################

  always_comb begin
    next_state = state;
    case (state)
      pcs_state_pkg::loss_of_alignment: begin
        if (got_align) begin
          next_state = pcs_state_pkg::align_detect_1;
        end
      end
      pcs_state_pkg::align_detect_1: begin
        if (got_align) begin
          next_state = pcs_state_pkg::align_detect_2;
        end else if (align_error) begin
          next_state = pcs_state_pkg::loss_of_alignment;
        end
      end
      pcs_state_pkg::align_detect_2: begin
        if (got_align) begin
          next_state = pcs_state_pkg::align_detect_3;
        end else if (align_error) begin
          next_state = pcs_state_pkg::loss_of_alignment;
        end
      end
      pcs_state_pkg::align_detect_3: begin
        if (got_align) begin
          next_state = pcs_state_pkg::align_acquired_1;
        end else if (align_error) begin
          next_state = pcs_state_pkg::loss_of_alignment;
        end
      end
      pcs_state_pkg::align_acquired_1: begin
        if (align_error) begin
          next_state = pcs_state_pkg::align_acquired_2;
        end
      end
      pcs_state_pkg::align_acquired_2: begin
        if (align_error) begin
          next_state = pcs_state_pkg::align_acquired_3;
        end else if (got_align) begin
          next_state = pcs_state_pkg::align_acquired_1;
        end
      end
      pcs_state_pkg::align_acquired_3: begin
        if (align_error) begin
          next_state = pcs_state_pkg::align_acquired_4;
        end else if (got_align) begin
          next_state = pcs_state_pkg::align_acquired_2;
        end
      end
      pcs_state_pkg::align_acquired_4: begin
        if (align_error) begin
          next_state = pcs_state_pkg::loss_of_alignment; // Fourth strike.
        end else if (got_align) begin
          next_state = pcs_state_pkg::align_acquired_3;
        end
      end
      default: begin
        next_state = pcs_state_pkg::loss_of_alignment;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset || (sync_status != '1)) begin
      state <= pcs_state_pkg::loss_of_alignment; // Any lane out of sync restarts.
    end else begin
      state <= next_state;
    end
  end

  assign enable_deskew = (state == pcs_state_pkg::loss_of_alignment);
  assign align_status = (state == pcs_state_pkg::align_acquired_1) ||
                        (state == pcs_state_pkg::align_acquired_2) ||
                        (state == pcs_state_pkg::align_acquired_3) ||
                        (state == pcs_state_pkg::align_acquired_4);

endmodule

// File: rtl/xaui_rx_pcs.sv
`timescale 1ns/1ps

module xaui_rx_pcs #(
  parameter int max_skew = 6
) (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [xaui_code_pkg::bus_width-1:0]  rx_data,
  input  logic [xaui_code_pkg::lane_count-1:0] rx_charisk,
  input  logic [xaui_code_pkg::lane_count-1:0] rx_disp_err,
  output logic [xaui_code_pkg::bus_width-1:0]  out_data,
  output logic [xaui_code_pkg::lane_count-1:0] out_charisk,
  output logic [xaui_code_pkg::lane_count-1:0] sync_status,
  output logic                               enable_deskew,
  output logic                               align_status
);

  localparam int lw = xaui_code_pkg::lane_width;

  logic [xaui_code_pkg::lane_count-1:0] aligned_disp_err;

  // ##############################
  // Per-lane code-group sync
  // ##############################

  for (genvar l = 0; l < xaui_code_pkg::lane_count; l++) begin : g_sync
    pcs_sync u_sync (
      .clk           (clk),
      .reset         (reset),
      .lane_data     (rx_data[l*lw +: lw]),
      .lane_charisk  (rx_charisk[l]),
      .lane_disp_err (rx_disp_err[l]),
      .lane_sync     (sync_status[l])
    );
  end

  // ##############################
  // Skew removal
  // ##############################

  // Aligned stream feeds both the outputs and the alignment machine.
  lane_aligner #(
    .max_skew (max_skew)
  ) u_aligner (
    .clk              (clk),
    .reset            (reset),
    .rx_data          (rx_data),
    .rx_charisk       (rx_charisk),
    .rx_disp_err      (rx_disp_err),
    .enable_deskew    (enable_deskew),
    .aligned_data     (out_data),
    .aligned_charisk  (out_charisk),
    .aligned_disp_err (aligned_disp_err)
  );

  pcs_deskew u_deskew (
    .clk              (clk),
    .reset            (reset),
    .aligned_data     (out_data),
    .aligned_charisk  (out_charisk),
    .aligned_disp_err (aligned_disp_err),
    .sync_status      (sync_status),
    .enable_deskew    (enable_deskew),
    .align_status     (align_status)
  );

endmodule

// File: tb/tb_xaui_rx_pcs.sv
`timescale 1ns/1ps

module tb_xaui_rx_pcs;

  parameter int max_skew = 6;

  localparam int lanes = xaui_code_pkg::lane_count;
  localparam int lw = xaui_code_pkg::lane_width;
  localparam int a_period = 16; // One /A/ column in every 16.
  localparam int comma_len = 24 + max_skew;
  localparam int align_limit = 4 * a_period + max_skew + 8;

  localparam logic [1:0] mode_idle = 2'd0;
  localparam logic [1:0] mode_comma = 2'd1;
  localparam logic [1:0] mode_data = 2'd2;

  logic                                clk;
  logic                                reset;
  logic [xaui_code_pkg::bus_width-1:0] rx_data;
  logic [lanes-1:0]                    rx_charisk;
  logic [lanes-1:0]                    rx_disp_err;
  logic [xaui_code_pkg::bus_width-1:0] out_data;
  logic [lanes-1:0]                    out_charisk;
  logic [lanes-1:0]                    sync_status;
  logic                                enable_deskew;
  logic                                align_status;

  logic [1:0]    mode;
  int            col_idx;   // Data columns generated so far.
  logic [7:0]    data_byte;
  int            delay [lanes];
  logic [lw+1:0] hist [max_skew][lanes]; // Past source columns, newest first.
  int            run_cnt [lanes];        // Clean commas in a row at the DUT input.
  int            errors;
  int            timeouts;

  xaui_rx_pcs #(
    .max_skew (max_skew)
  ) dut (
    .clk           (clk),
    .reset         (reset),
    .rx_data       (rx_data),
    .rx_charisk    (rx_charisk),
    .rx_disp_err   (rx_disp_err),
    .out_data      (out_data),
    .out_charisk   (out_charisk),
    .sync_status   (sync_status),
    .enable_deskew (enable_deskew),
    .align_status  (align_status)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ##############################
  // Helpers
  // ##############################

  task automatic flag_error(input string msg);
    errors++;
    $display("** Error at %0t ns: %s", $time, msg);
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("Timeout while waiting for %s.", what);
  endtask

  function automatic logic [7:0] next_data_byte(input logic [7:0] b);
    logic [7:0] n;
    n = b + 8'd1;
    while (n == xaui_code_pkg::sym_k || n == xaui_code_pkg::sym_a ||
           n == xaui_code_pkg::sym_r) begin
      n = n + 8'd1;
    end
    return n;
  endfunction

  function automatic logic [lanes-1:0] lane_mask(input int lane);
    logic [lanes-1:0] m;
    m = '0;
    m[lane] = 1'b1;
    return m;
  endfunction

  function automatic logic lanes_equal(input logic [xaui_code_pkg::bus_width-1:0] bus);
    logic eq;
    eq = 1'b1;
    for (int l = 1; l < lanes; l++) begin
      eq = eq && (bus[l*lw +: lw] == bus[lw-1:0]);
    end
    return eq;
  endfunction

  // One column per clock, each lane through its own delay line.
  task automatic send_column(input logic [lanes-1:0] err);
    logic [lw+1:0]                       src [lanes];
    logic [lw+1:0]                       cur;
    logic [xaui_code_pkg::bus_width-1:0] d;
    logic [lanes-1:0]                    k;
    logic [lanes-1:0]                    e;
    logic [7:0]                          sym;
    logic                                is_k;
    @(posedge clk);
    case (mode)
      mode_comma: begin
        sym = xaui_code_pkg::sym_k;
        is_k = 1'b1;
      end
      mode_data: begin
        if (col_idx % a_period == 0) begin
          sym = xaui_code_pkg::sym_a;
          is_k = 1'b1;
        end else begin
          data_byte = next_data_byte(data_byte);
          sym = data_byte;
          is_k = 1'b0;
        end
        col_idx++;
      end
      default: begin
        sym = 8'h00;
        is_k = 1'b0;
      end
    endcase
    for (int l = 0; l < lanes; l++) begin
      src[l] = {err[l], is_k, sym};
      cur = (delay[l] == 0) ? src[l] : hist[delay[l]-1][l];
      {e[l], k[l], d[l*lw +: lw]} = cur;
    end
    for (int i = max_skew - 1; i > 0; i--) begin
      for (int l = 0; l < lanes; l++) begin
        hist[i][l] = hist[i-1][l];
      end
    end
    for (int l = 0; l < lanes; l++) begin
      hist[0][l] = src[l];
    end
    rx_data <= d;
    rx_charisk <= k;
    rx_disp_err <= e;
  endtask

  task automatic advance_to_column(input int pos);
    int n;
    n = 0;
    while (col_idx % a_period != pos && n < a_period) begin
      send_column('0);
      n++;
    end
    if (col_idx % a_period != pos) begin
      note_timeout($sformatf("data column position %0d", pos));
    end
  endtask

  task automatic wait_for_align(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (align_status !== level && n < limit) begin
      send_column('0);
      n++;
    end
    if (align_status !== level) begin
      note_timeout(what);
    end
  endtask

  // ##############################
  // Checks
  // ##############################

  always @(posedge clk) begin
    for (int l = 0; l < lanes; l++) begin
      if (reset) begin
        run_cnt[l] <= 0;
      end else if (rx_charisk[l] && !rx_disp_err[l] &&
                   rx_data[l*lw +: lw] == xaui_code_pkg::sym_k) begin
        run_cnt[l] <= run_cnt[l] + 1;
      end else begin
        run_cnt[l] <= 0;
      end
    end
  end

  for (genvar l = 0; l < lanes; l++) begin : g_sync_check
    assert property (@(posedge clk) disable iff (reset)
      $rose(sync_status[l]) |-> run_cnt[l] >= xaui_code_pkg::sync_comma_count)
      else flag_error($sformatf("lane %0d gained sync before enough clean commas", l));
  end

  assert property (@(posedge clk) disable iff (reset) align_status |-> !enable_deskew)
    else flag_error("enable_deskew high while align_status is high");

  assert property (@(posedge clk) disable iff (reset) align_status |-> lanes_equal(out_data))
    else flag_error($sformatf("out_data lanes differ while aligned: %h", out_data));

  assert property (@(posedge clk) disable iff (reset)
    align_status |-> ((out_charisk == '1) == (out_data == {lanes{xaui_code_pkg::sym_a}})))
    else flag_error($sformatf("out_charisk %b does not match out_data %h", out_charisk, out_data));

  assert property (@(posedge clk) disable iff (reset) (sync_status != '1) |=> !align_status)
    else flag_error("align_status high after a lane was out of sync");

  // ##############################
  // Stimulus
  // ##############################

  initial begin
    int err_lane;
    int sync_lane;
    int n;
    void'($urandom(48));
    reset = 1'b1;
    rx_data = '0;
    rx_charisk = '0;
    rx_disp_err = '0;
    mode = mode_idle;
    col_idx = 0;
    data_byte = 8'h00;
    errors = 0;
    timeouts = 0;
    for (int l = 0; l < lanes; l++) begin
      delay[l] = $urandom % max_skew;
      for (int i = 0; i < max_skew; i++) begin
        hist[i][l] = '0;
      end
    end
    $display("Lane delays: %0d %0d %0d %0d", delay[0], delay[1], delay[2], delay[3]);
    send_column('0);
    send_column('0);
    reset <= 1'b0;

    // Reset state, before any comma.
    send_column('0);
    send_column('0);
    assert (sync_status == '0)
      else flag_error($sformatf("sync_status %b after reset", sync_status));
    assert (align_status == 1'b0) else flag_error("align_status high after reset");
    assert (enable_deskew == 1'b1) else flag_error("enable_deskew low after reset");

    // Comma phase with one error inside the first run.
    err_lane = $urandom % lanes;
    mode = mode_comma;
    send_column('0);
    send_column('0);
    send_column(lane_mask(err_lane));
    for (n = 3; n < comma_len; n++) begin
      send_column('0);
    end
    assert (sync_status == '1)
      else flag_error($sformatf("sync_status %b at end of comma phase", sync_status));

    // Data phase and first alignment.
    mode = mode_data;
    col_idx = 0;
    wait_for_align(1'b1, align_limit, "align_status to rise");
    repeat (2 * a_period) send_column('0);

    // Four errors in one /A/ interval, one per lane.
    advance_to_column(2);
    for (n = 0; n < lanes; n++) begin
      send_column(lane_mask(n));
      send_column('0);
    end
    wait_for_align(1'b0, a_period, "align_status to fall after four errors");
    assert (enable_deskew == 1'b1) else flag_error("enable_deskew low after alignment loss");
    assert (sync_status == '1) else flag_error("sync lost on spread errors");

    // Realign, then a single error is healed by the next /A/.
    wait_for_align(1'b1, align_limit, "align_status to rise again");
    advance_to_column(4);
    send_column(lane_mask(err_lane));
    for (n = 0; n < a_period + max_skew + 4; n++) begin
      send_column('0);
      assert (align_status == 1'b1) else flag_error("align_status fell after a single error");
    end

    // Burst of errors on one lane drops its sync.
    // The /A/ column in the middle keeps the alignment machine short of its fourth strike.
    sync_lane = (err_lane + 1) % lanes;
    advance_to_column(a_period - 3);
    for (n = 0; n < xaui_code_pkg::sync_error_limit; n++) begin
      send_column(lane_mask(sync_lane));
      send_column('0);
    end
    n = 0;
    while (sync_status[sync_lane] && n < max_skew + 8) begin
      send_column('0);
      n++;
    end
    if (sync_status[sync_lane]) begin
      note_timeout($sformatf("sync_status[%0d] to fall", sync_lane));
    end else begin
      send_column('0);
      assert (align_status == 1'b0) else flag_error("align_status high after sync loss");
    end

    $display("Done with %0d errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: xaui_rx_pcs.f
rtl/xaui_code_pkg.sv
rtl/pcs_state_pkg.sv
rtl/pcs_sync.sv
rtl/lane_aligner.sv
rtl/pcs_deskew.sv
rtl/xaui_rx_pcs.sv
tb/tb_xaui_rx_pcs.sv
